//--- common/id_config.svh
`ifndef ID_CONFIG_SVH
`define ID_CONFIG_SVH

// datapath and address width
`define ID_XLEN 32

// register file address width
`define ID_REG_AW 5

// byte step to the next instruction
`define ID_PC_STEP 4

// jumps always link into x1
`define ID_LINK_REG 1

`endif

//--- common/id_pkg.sv
package id_pkg;

	// major opcodes
	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_LOAD   = 7'b0000011;
	localparam logic [6:0] OPC_STORE  = 7'b0100011;
	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
	localparam logic [6:0] OPC_JAL    = 7'b1101111;
	localparam logic [6:0] OPC_JALR   = 7'b1100111;

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0] imm_11_0;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} i_fmt_t;

	typedef struct packed {
		logic [6:0] imm_11_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm_4_0;
		logic [6:0] opcode;
	} s_fmt_t;

	typedef struct packed {
		logic       imm_12;
		logic [5:0] imm_10_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [3:0] imm_4_1;
		logic       imm_11;
		logic [6:0] opcode;
	} b_fmt_t;

	typedef struct packed {
		logic [19:0] imm_31_12;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} u_fmt_t;

	typedef struct packed {
		logic       imm_20;
		logic [9:0] imm_10_1;
		logic       imm_11;
		logic [7:0] imm_19_12;
		logic [4:0] rd;
		logic [6:0] opcode;
	} j_fmt_t;

	// one instruction word, six views
	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
		s_fmt_t s;
		b_fmt_t b;
		u_fmt_t u;
		j_fmt_t j;
	} inst_t;

	typedef enum logic [5:0] {
		ALU_NOP, ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_AND, ALU_OR, ALU_XOR,
		ALU_SLL, ALU_SRL, ALU_SRA,
		ALU_BEQ, ALU_BNE, ALU_BLT, ALU_BGE, ALU_BLTU, ALU_BGEU, ALU_JAL, ALU_JALR,
		ALU_LB, ALU_LH, ALU_LW, ALU_LBU, ALU_LHU, ALU_SB, ALU_SH, ALU_SW
	} aluop_e;

	typedef enum logic [2:0] {
		SEL_NOP, SEL_LOGIC, SEL_SHIFT, SEL_ARITH, SEL_JUMP_BRANCH, SEL_LOAD_STORE
	} alusel_e;

	typedef enum logic [1:0] {SRC_REG, SRC_IMM, SRC_PC, SRC_ZERO} opnd_src_e;

	typedef enum logic [2:0] {
		IMM_NONE, IMM_I, IMM_SHAMT, IMM_S, IMM_B, IMM_U, IMM_J
	} imm_fmt_e;

	// nine kinds, so four bits
	typedef enum logic [3:0] {
		BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU, BR_JAL, BR_JALR
	} br_kind_e;

endpackage

//--- decode/id_decoder.sv
`timescale 1ns/100ps
`include "id_config.svh"

module id_decoder (
	input  id_pkg::inst_t            inst_i,
	output id_pkg::aluop_e           aluop_o,
	output id_pkg::alusel_e          alusel_o,
	output logic                     reg1_read_o,
	output logic                     reg2_read_o,
	output logic [`ID_REG_AW-1:0]    reg1_addr_o,
	output logic [`ID_REG_AW-1:0]    reg2_addr_o,
	output logic [`ID_REG_AW-1:0]    wd_o,
	output logic                     wreg_o,
	output id_pkg::imm_fmt_e         imm_fmt_o,
	output id_pkg::opnd_src_e        src1_o,
	output id_pkg::opnd_src_e        src2_o,
	output id_pkg::br_kind_e         br_kind_o
);

	logic [2:0] f3;
	logic [6:0] f7;
	logic       shift_imm;
	logic       r_legal;
	logic       i_legal;

	assign f3 = inst_i.r.funct3;
	assign f7 = inst_i.r.funct7;
	assign shift_imm = (f3[1:0] == 2'b01); // slli, srli, srai
	assign r_legal = (f7 == 7'b0000000) ||
		(f7 == 7'b0100000 && (f3 == 3'b000 || f3 == 3'b101));
	assign i_legal = !shift_imm || (f7 == 7'b0000000) ||
		(f3 == 3'b101 && f7 == 7'b0100000);

	// shared by OP and OP_IMM, alt picks sub / sra
	function automatic id_pkg::aluop_e alu_op(input logic [2:0] funct3, input logic alt);
		case (funct3)
			3'b000:  alu_op = alt ? id_pkg::ALU_SUB : id_pkg::ALU_ADD;
			3'b001:  alu_op = id_pkg::ALU_SLL;
			3'b010:  alu_op = id_pkg::ALU_SLT;
			3'b011:  alu_op = id_pkg::ALU_SLTU;
			3'b100:  alu_op = id_pkg::ALU_XOR;
			3'b101:  alu_op = alt ? id_pkg::ALU_SRA : id_pkg::ALU_SRL;
			3'b110:  alu_op = id_pkg::ALU_OR;
			default: alu_op = id_pkg::ALU_AND;
		endcase
	endfunction

	function automatic id_pkg::alusel_e class_of(input id_pkg::aluop_e op);
		case (op)
			id_pkg::ALU_AND, id_pkg::ALU_OR, id_pkg::ALU_XOR:
				class_of = id_pkg::SEL_LOGIC;
			id_pkg::ALU_SLL, id_pkg::ALU_SRL, id_pkg::ALU_SRA:
				class_of = id_pkg::SEL_SHIFT;
			id_pkg::ALU_ADD, id_pkg::ALU_SUB, id_pkg::ALU_SLT, id_pkg::ALU_SLTU:
				class_of = id_pkg::SEL_ARITH;
			id_pkg::ALU_BEQ, id_pkg::ALU_BNE, id_pkg::ALU_BLT, id_pkg::ALU_BGE,
			id_pkg::ALU_BLTU, id_pkg::ALU_BGEU, id_pkg::ALU_JAL, id_pkg::ALU_JALR:
				class_of = id_pkg::SEL_JUMP_BRANCH;
			id_pkg::ALU_NOP:
				class_of = id_pkg::SEL_NOP;
			default:
				class_of = id_pkg::SEL_LOAD_STORE;
		endcase
	endfunction

	function automatic id_pkg::br_kind_e kind_of(input id_pkg::aluop_e op);
		case (op)
			id_pkg::ALU_BEQ:  kind_of = id_pkg::BR_EQ;
			id_pkg::ALU_BNE:  kind_of = id_pkg::BR_NE;
			id_pkg::ALU_BLT:  kind_of = id_pkg::BR_LT;
			id_pkg::ALU_BGE:  kind_of = id_pkg::BR_GE;
			id_pkg::ALU_BLTU: kind_of = id_pkg::BR_LTU;
			id_pkg::ALU_BGEU: kind_of = id_pkg::BR_GEU;
			id_pkg::ALU_JAL:  kind_of = id_pkg::BR_JAL;
			id_pkg::ALU_JALR: kind_of = id_pkg::BR_JALR;
			default:          kind_of = id_pkg::BR_NONE;
		endcase
	endfunction

	assign alusel_o = class_of(aluop_o);
	assign br_kind_o = kind_of(aluop_o);
	assign reg1_addr_o = reg1_read_o ? inst_i.r.rs1 : '0; // idle port reads x0
	assign reg2_addr_o = reg2_read_o ? inst_i.r.rs2 : '0;

	always_comb begin
		aluop_o = id_pkg::ALU_NOP;
		reg1_read_o = 1'b0;
		reg2_read_o = 1'b0;
		wd_o = inst_i.r.rd;
		wreg_o = 1'b0;
		imm_fmt_o = id_pkg::IMM_NONE;
		src1_o = id_pkg::SRC_ZERO;
		src2_o = id_pkg::SRC_ZERO;
		case (inst_i.r.opcode)
			id_pkg::OPC_OP: begin
				aluop_o = r_legal ? alu_op(f3, f7[5]) : id_pkg::ALU_NOP;
				reg1_read_o = 1'b1;
				reg2_read_o = 1'b1;
				wreg_o = 1'b1;
				src1_o = id_pkg::SRC_REG;
				src2_o = id_pkg::SRC_REG;
			end
			id_pkg::OPC_OP_IMM: begin
				aluop_o = i_legal ? alu_op(f3, shift_imm & f7[5]) : id_pkg::ALU_NOP;
				reg1_read_o = 1'b1;
				wreg_o = 1'b1;
				imm_fmt_o = shift_imm ? id_pkg::IMM_SHAMT : id_pkg::IMM_I;
				src1_o = id_pkg::SRC_REG;
				src2_o = id_pkg::SRC_IMM;
			end
			id_pkg::OPC_BRANCH: begin
				case (f3)
					3'b000:  aluop_o = id_pkg::ALU_BEQ;
					3'b001:  aluop_o = id_pkg::ALU_BNE;
					3'b100:  aluop_o = id_pkg::ALU_BLT;
					3'b101:  aluop_o = id_pkg::ALU_BGE;
					3'b110:  aluop_o = id_pkg::ALU_BLTU;
					3'b111:  aluop_o = id_pkg::ALU_BGEU;
					default: aluop_o = id_pkg::ALU_NOP;
				endcase
				reg1_read_o = 1'b1;
				reg2_read_o = 1'b1;
				imm_fmt_o = id_pkg::IMM_B;
				src1_o = id_pkg::SRC_REG;
				src2_o = id_pkg::SRC_REG;
			end
			id_pkg::OPC_LOAD: begin
				case (f3)
					3'b000:  aluop_o = id_pkg::ALU_LB;
					3'b001:  aluop_o = id_pkg::ALU_LH;
					3'b010:  aluop_o = id_pkg::ALU_LW;
					3'b100:  aluop_o = id_pkg::ALU_LBU;
					3'b101:  aluop_o = id_pkg::ALU_LHU;
					default: aluop_o = id_pkg::ALU_NOP;
				endcase
				reg1_read_o = 1'b1;
				wreg_o = 1'b1;
				imm_fmt_o = id_pkg::IMM_I;
				src1_o = id_pkg::SRC_REG;
				src2_o = id_pkg::SRC_IMM;
			end
			id_pkg::OPC_STORE: begin
				case (f3)
					3'b000:  aluop_o = id_pkg::ALU_SB;
					3'b001:  aluop_o = id_pkg::ALU_SH;
					3'b010:  aluop_o = id_pkg::ALU_SW;
					default: aluop_o = id_pkg::ALU_NOP;
				endcase
				reg1_read_o = 1'b1;
				reg2_read_o = 1'b1; // offset rides along in inst_o
				imm_fmt_o = id_pkg::IMM_S;
				src1_o = id_pkg::SRC_REG;
				src2_o = id_pkg::SRC_REG;
			end
			id_pkg::OPC_LUI: begin
				aluop_o = id_pkg::ALU_OR; // 0 | imm
				wreg_o = 1'b1;
				imm_fmt_o = id_pkg::IMM_U;
				src2_o = id_pkg::SRC_IMM;
			end
			id_pkg::OPC_AUIPC: begin
				aluop_o = id_pkg::ALU_ADD;
				wreg_o = 1'b1;
				imm_fmt_o = id_pkg::IMM_U;
				src1_o = id_pkg::SRC_PC;
				src2_o = id_pkg::SRC_IMM;
			end
			id_pkg::OPC_JAL: begin
				aluop_o = id_pkg::ALU_JAL;
				wreg_o = 1'b1;
				wd_o = `ID_REG_AW'(`ID_LINK_REG);
				imm_fmt_o = id_pkg::IMM_J;
			end
			id_pkg::OPC_JALR: begin
				aluop_o = (f3 == 3'b000) ? id_pkg::ALU_JALR : id_pkg::ALU_NOP;
				reg1_read_o = 1'b1;
				wreg_o = 1'b1;
				wd_o = `ID_REG_AW'(`ID_LINK_REG);
				imm_fmt_o = id_pkg::IMM_I;
				src1_o = id_pkg::SRC_REG;
				src2_o = id_pkg::SRC_IMM;
			end
			default: ;
		endcase
		// unknown encoding leaves nothing behind
		if (aluop_o == id_pkg::ALU_NOP) begin
			reg1_read_o = 1'b0;
			reg2_read_o = 1'b0;
			wd_o = '0;
			wreg_o = 1'b0;
			imm_fmt_o = id_pkg::IMM_NONE;
			src1_o = id_pkg::SRC_ZERO;
			src2_o = id_pkg::SRC_ZERO;
		end
	end

endmodule

//--- decode/imm_gen.sv
`timescale 1ns/100ps
`include "id_config.svh"

module imm_gen (
	input  id_pkg::inst_t        inst_i,
	input  id_pkg::imm_fmt_e     imm_fmt_i,
	output logic [`ID_XLEN-1:0]  imm_o
);

	always_comb begin
		case (imm_fmt_i)
			id_pkg::IMM_I:
				imm_o = {{20{inst_i.i.imm_11_0[11]}}, inst_i.i.imm_11_0};
			id_pkg::IMM_SHAMT:
				imm_o = `ID_XLEN'(inst_i.r.rs2); // shamt sits in the rs2 slot
			id_pkg::IMM_S:
				imm_o = {{20{inst_i.s.imm_11_5[6]}}, inst_i.s.imm_11_5, inst_i.s.imm_4_0};
			id_pkg::IMM_B:
				imm_o = {{20{inst_i.b.imm_12}}, inst_i.b.imm_11, inst_i.b.imm_10_5,
					inst_i.b.imm_4_1, 1'b0};
			id_pkg::IMM_U:
				imm_o = {inst_i.u.imm_31_12, 12'b0};
			id_pkg::IMM_J:
				imm_o = {{12{inst_i.j.imm_20}}, inst_i.j.imm_19_12, inst_i.j.imm_11,
					inst_i.j.imm_10_1, 1'b0};
			default:
				imm_o = '0;
		endcase
	end

endmodule

//--- design/operand_mux.sv
`timescale 1ns/100ps
`include "id_config.svh"

module operand_mux (
	input  id_pkg::opnd_src_e       src_i,
	input  logic [`ID_REG_AW-1:0]   addr_i,
	input  logic [`ID_XLEN-1:0]     rf_data_i,
	input  logic [`ID_XLEN-1:0]     imm_i,
	input  logic [`ID_XLEN-1:0]     pc_i,
	input  logic                    ex_wreg_i,
	input  logic [`ID_REG_AW-1:0]   ex_wd_i,
	input  logic                    ex_load_i,
	input  logic [`ID_XLEN-1:0]     ex_wdata_i,
	input  logic                    mem_wreg_i,
	input  logic [`ID_REG_AW-1:0]   mem_wd_i,
	input  logic [`ID_XLEN-1:0]     mem_wdata_i,
	output logic [`ID_XLEN-1:0]     opnd_o
);

	logic ex_hit;
	logic mem_hit;

	// x0 never forwards; a load in EX has no value yet
	assign ex_hit = ex_wreg_i && !ex_load_i && (ex_wd_i == addr_i) && (addr_i != '0);
	assign mem_hit = mem_wreg_i && (mem_wd_i == addr_i) && (addr_i != '0);

	always_comb begin
		case (src_i)
			id_pkg::SRC_REG: begin
				if (ex_hit)
					opnd_o = ex_wdata_i; // youngest wins
				else if (mem_hit)
					opnd_o = mem_wdata_i;
				else
					opnd_o = rf_data_i;
			end
			id_pkg::SRC_IMM: opnd_o = imm_i;
			id_pkg::SRC_PC:  opnd_o = pc_i;
			default:         opnd_o = '0;
		endcase
	end

endmodule

//--- design/hazard_unit.sv
`timescale 1ns/100ps
`include "id_config.svh"

module hazard_unit (
	input  logic                    ex_load_i,
	input  logic [`ID_REG_AW-1:0]   ex_wd_i,
	input  logic                    reg1_read_i,
	input  logic [`ID_REG_AW-1:0]   reg1_addr_i,
	input  logic                    reg2_read_i,
	input  logic [`ID_REG_AW-1:0]   reg2_addr_i,
	output logic                    stall_o
);

	logic rs1_dep;
	logic rs2_dep;

	assign rs1_dep = reg1_read_i && (reg1_addr_i == ex_wd_i);
	assign rs2_dep = reg2_read_i && (reg2_addr_i == ex_wd_i);

	// one cycle is enough, the load reaches MEM next
	assign stall_o = ex_load_i && (ex_wd_i != '0) && (rs1_dep || rs2_dep);

endmodule

//--- design/branch_unit.sv
`timescale 1ns/100ps
`include "id_config.svh"

module branch_unit (
	input  id_pkg::br_kind_e       br_kind_i,
	input  logic [`ID_XLEN-1:0]    opnd1_i,
	input  logic [`ID_XLEN-1:0]    opnd2_i,
	input  logic [`ID_XLEN-1:0]    imm_i,
	input  logic [`ID_XLEN-1:0]    pc_i,
	output logic                   branch_flag_o,
	output logic [`ID_XLEN-1:0]    branch_target_o,
	output logic [`ID_XLEN-1:0]    link_addr_o
);

	logic is_jump;
	logic lt_s;
	logic lt_u;
	logic [`ID_XLEN-1:0] jalr_sum;

	assign is_jump = (br_kind_i == id_pkg::BR_JAL) || (br_kind_i == id_pkg::BR_JALR);
	assign lt_s = $signed(opnd1_i) < $signed(opnd2_i);
	assign lt_u = opnd1_i < opnd2_i;
	assign jalr_sum = opnd1_i + imm_i;

	always_comb begin
		case (br_kind_i)
			id_pkg::BR_EQ:  branch_flag_o = (opnd1_i == opnd2_i);
			id_pkg::BR_NE:  branch_flag_o = (opnd1_i != opnd2_i);
			id_pkg::BR_LT:  branch_flag_o = lt_s;
			id_pkg::BR_GE:  branch_flag_o = !lt_s;
			id_pkg::BR_LTU: branch_flag_o = lt_u;
			id_pkg::BR_GEU: branch_flag_o = !lt_u;
			default:        branch_flag_o = is_jump;
		endcase
	end

	always_comb begin
		if (!branch_flag_o)
			branch_target_o = '0;
		else if (br_kind_i == id_pkg::BR_JALR)
			branch_target_o = {jalr_sum[`ID_XLEN-1:1], 1'b0}; // lsb dropped per spec
		else
			branch_target_o = pc_i + imm_i;
	end

	assign link_addr_o = is_jump ? pc_i + `ID_XLEN'(`ID_PC_STEP) : '0;

endmodule

//--- design/id_ex_reg.sv
`timescale 1ns/100ps
`include "id_config.svh"

module id_ex_reg (
	input  logic                    clk,
	input  logic                    reset_i,
	input  logic                    stall_i,
	input  id_pkg::aluop_e          aluop_i,
	input  id_pkg::alusel_e         alusel_i,
	input  logic [`ID_XLEN-1:0]     reg1_i,
	input  logic [`ID_XLEN-1:0]     reg2_i,
	input  logic [`ID_REG_AW-1:0]   wd_i,
	input  logic                    wreg_i,
	input  logic [`ID_XLEN-1:0]     inst_i,
	output id_pkg::aluop_e          aluop_o,
	output id_pkg::alusel_e         alusel_o,
	output logic [`ID_XLEN-1:0]     reg1_o,
	output logic [`ID_XLEN-1:0]     reg2_o,
	output logic [`ID_REG_AW-1:0]   wd_o,
	output logic                    wreg_o,
	output logic [`ID_XLEN-1:0]     inst_o,
	output logic                    ex_load_o
);

	always_ff @(posedge clk) begin
		if (reset_i || stall_i) begin // bubble
			aluop_o <= id_pkg::ALU_NOP;
			alusel_o <= id_pkg::SEL_NOP;
			wd_o <= '0;
			wreg_o <= 1'b0;
		end else begin
			aluop_o <= aluop_i;
			alusel_o <= alusel_i;
			wd_o <= wd_i;
			wreg_o <= wreg_i;
		end
	end

	always_ff @(posedge clk) begin
		reg1_o <= reg1_i;
		reg2_o <= reg2_i;
		inst_o <= inst_i;
	end

	// stores never set wreg
	assign ex_load_o = wreg_o && (alusel_o == id_pkg::SEL_LOAD_STORE);

endmodule

//--- design/id_stage.sv
`timescale 1ns/100ps
`include "id_config.svh"

module id_stage (
	input  logic                    clk,
	input  logic                    reset_i,
	input  logic [31:0]             inst_i,
	input  logic [`ID_XLEN-1:0]     pc_i,
	input  logic [`ID_XLEN-1:0]     reg1_data_i,
	input  logic [`ID_XLEN-1:0]     reg2_data_i,
	input  logic [`ID_XLEN-1:0]     ex_wdata_i,
	input  logic                    mem_wreg_i,
	input  logic [`ID_REG_AW-1:0]   mem_wd_i,
	input  logic [`ID_XLEN-1:0]     mem_wdata_i,
	output logic [`ID_REG_AW-1:0]   reg1_addr_o,
	output logic [`ID_REG_AW-1:0]   reg2_addr_o,
	output logic                    reg1_read_o,
	output logic                    reg2_read_o,
	output id_pkg::aluop_e          aluop_o,
	output id_pkg::alusel_e         alusel_o,
	output logic [`ID_XLEN-1:0]     reg1_o,
	output logic [`ID_XLEN-1:0]     reg2_o,
	output logic [`ID_REG_AW-1:0]   wd_o,
	output logic                    wreg_o,
	output logic [`ID_XLEN-1:0]     inst_o,
	output logic                    branch_flag_o,
	output logic [`ID_XLEN-1:0]     branch_target_o,
	output logic [`ID_XLEN-1:0]     link_addr_o,
	output logic                    stall_o
);

	id_pkg::aluop_e      aluop_d;
	id_pkg::alusel_e     alusel_d;
	id_pkg::imm_fmt_e    imm_fmt;
	id_pkg::opnd_src_e   src1;
	id_pkg::opnd_src_e   src2;
	id_pkg::br_kind_e    br_kind;
	logic [`ID_REG_AW-1:0] wd_d;
	logic                wreg_d;
	logic [`ID_XLEN-1:0] imm;
	logic [`ID_XLEN-1:0] opnd1;
	logic [`ID_XLEN-1:0] opnd2;
	logic                ex_load;

	id_decoder u_dec (
		.inst_i(inst_i), .aluop_o(aluop_d), .alusel_o(alusel_d),
		.reg1_read_o(reg1_read_o), .reg2_read_o(reg2_read_o),
		.reg1_addr_o(reg1_addr_o), .reg2_addr_o(reg2_addr_o),
		.wd_o(wd_d), .wreg_o(wreg_d), .imm_fmt_o(imm_fmt),
		.src1_o(src1), .src2_o(src2), .br_kind_o(br_kind)
	);

	imm_gen u_imm (.inst_i(inst_i), .imm_fmt_i(imm_fmt), .imm_o(imm));

	// EX tags come from our own ID/EX register
	operand_mux u_opnd1 (
		.src_i(src1), .addr_i(reg1_addr_o), .rf_data_i(reg1_data_i), .imm_i(imm),
		.pc_i(pc_i), .ex_wreg_i(wreg_o), .ex_wd_i(wd_o), .ex_load_i(ex_load),
		.ex_wdata_i(ex_wdata_i), .mem_wreg_i(mem_wreg_i), .mem_wd_i(mem_wd_i),
		.mem_wdata_i(mem_wdata_i), .opnd_o(opnd1)
	);

	operand_mux u_opnd2 (
		.src_i(src2), .addr_i(reg2_addr_o), .rf_data_i(reg2_data_i), .imm_i(imm),
		.pc_i(pc_i), .ex_wreg_i(wreg_o), .ex_wd_i(wd_o), .ex_load_i(ex_load),
		.ex_wdata_i(ex_wdata_i), .mem_wreg_i(mem_wreg_i), .mem_wd_i(mem_wd_i),
		.mem_wdata_i(mem_wdata_i), .opnd_o(opnd2)
	);

	hazard_unit u_haz (
		.ex_load_i(ex_load), .ex_wd_i(wd_o),
		.reg1_read_i(reg1_read_o), .reg1_addr_i(reg1_addr_o),
		.reg2_read_i(reg2_read_o), .reg2_addr_i(reg2_addr_o),
		.stall_o(stall_o)
	);

	branch_unit u_br (
		.br_kind_i(br_kind), .opnd1_i(opnd1), .opnd2_i(opnd2), .imm_i(imm), .pc_i(pc_i),
		.branch_flag_o(branch_flag_o), .branch_target_o(branch_target_o),
		.link_addr_o(link_addr_o)
	);

	id_ex_reg u_idex (
		.clk(clk), .reset_i(reset_i), .stall_i(stall_o),
		.aluop_i(aluop_d), .alusel_i(alusel_d), .reg1_i(opnd1), .reg2_i(opnd2),
		.wd_i(wd_d), .wreg_i(wreg_d), .inst_i(inst_i),
		.aluop_o(aluop_o), .alusel_o(alusel_o), .reg1_o(reg1_o), .reg2_o(reg2_o),
		.wd_o(wd_o), .wreg_o(wreg_o), .inst_o(inst_o), .ex_load_o(ex_load)
	);

endmodule

//--- verification/id_stage_assert.sv
`timescale 1ns/100ps
`include "id_config.svh"

module id_stage_assert (
	input logic                 clk,
	input logic                 reset_i,
	input logic                 stall_o,
	input logic                 wreg_o,
	input logic                 branch_flag_o,
	input logic [`ID_XLEN-1:0]  branch_target_o
);

	// stalled edge loads a bubble
	bubble_after_stall: assert property (@(posedge clk) disable iff (reset_i)
		stall_o |=> !wreg_o)
		else $error("wreg_o high in the cycle after a stall");

	reset_clears_wreg: assert property (@(posedge clk) reset_i |=> !wreg_o)
		else $error("wreg_o high after reset");

	target_zero_not_taken: assert property (@(posedge clk) disable iff (reset_i)
		!branch_flag_o |-> branch_target_o == '0)
		else $error("branch_target_o nonzero with branch not taken");

endmodule

bind id_stage id_stage_assert u_assert (.*);

//--- verification/tb_id_stage.sv
`timescale 1ns/100ps
`include "id_config.svh"

module tb_id_stage;

	localparam int NUM_INST = 600;
	localparam int CLK_HALF = 50;

	typedef struct packed {
		id_pkg::aluop_e  op;
		id_pkg::alusel_e sel;
		logic [31:0]     r1;
		logic [31:0]     r2;
		logic [4:0]      wd;
		logic            wreg;
		logic            use1;
		logic            use2;
		logic            flag;
		logic [31:0]     tgt;
		logic [31:0]     link;
		logic            stall;
		logic            load;
	} expect_t;

	logic clk;
	logic reset_i;
	logic [31:0] inst_i;
	logic [31:0] pc_i;
	logic [31:0] reg1_data_i;
	logic [31:0] reg2_data_i;
	logic [31:0] ex_wdata_i;
	logic mem_wreg_i;
	logic [4:0] mem_wd_i;
	logic [31:0] mem_wdata_i;
	logic [4:0] reg1_addr_o;
	logic [4:0] reg2_addr_o;
	logic reg1_read_o;
	logic reg2_read_o;
	id_pkg::aluop_e aluop_o;
	id_pkg::alusel_e alusel_o;
	logic [31:0] reg1_o;
	logic [31:0] reg2_o;
	logic [4:0] wd_o;
	logic wreg_o;
	logic [31:0] inst_o;
	logic branch_flag_o;
	logic [31:0] branch_target_o;
	logic [31:0] link_addr_o;
	logic stall_o;

	logic [31:0] rf [32]; // register file model
	logic [31:0] lfsr;
	logic checking;
	logic exp_stall;
	expect_t now_exp;
	expect_t pend; // bundle the DUT holds in ID/EX
	logic pend_bubble;
	logic [31:0] pend_inst;
	logic ex_wreg;
	logic ex_load;
	logic [4:0] ex_wd;
	int n_stall;
	int n_taken;

	id_stage dut (.*);

	assign reg1_data_i = rf[reg1_addr_o];
	assign reg2_data_i = rf[reg2_addr_o];

	initial begin
		clk = 1'b0;
		forever #CLK_HALF clk = ~clk;
	end

	// galois lfsr stepped once per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		int k;
		v = '0;
		for (k = 0; k < n; k++) begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	task automatic report_mismatch(input string msg);
		$display("Mismatch at %0t ns: %s", $time, msg);
		$display("SIMULATION FAILED");
		$fatal(1, "mismatch");
	endtask

	task automatic abort_run(input string msg);
		$display("Error: %s", msg);
		$display("SIMULATION FAILED");
		$fatal(1, "aborted");
	endtask

	// ex first, then mem, then the register file; x0 never forwards
	function automatic logic [31:0] forward_value(input logic [4:0] a);
		if (a != 5'd0 && ex_wreg && !ex_load && ex_wd == a)
			return ex_wdata_i;
		if (a != 5'd0 && mem_wreg_i && mem_wd_i == a)
			return mem_wdata_i;
		return rf[a];
	endfunction

	function automatic id_pkg::aluop_e arith_op(input logic [2:0] f3, input logic alt);
		case (f3)
			3'b000:  return alt ? id_pkg::ALU_SUB : id_pkg::ALU_ADD;
			3'b001:  return id_pkg::ALU_SLL;
			3'b010:  return id_pkg::ALU_SLT;
			3'b011:  return id_pkg::ALU_SLTU;
			3'b100:  return id_pkg::ALU_XOR;
			3'b101:  return alt ? id_pkg::ALU_SRA : id_pkg::ALU_SRL;
			3'b110:  return id_pkg::ALU_OR;
			default: return id_pkg::ALU_AND;
		endcase
	endfunction

	function automatic id_pkg::alusel_e sel_for_f3(input logic [2:0] f3);
		if (f3 == 3'b100 || f3 == 3'b110 || f3 == 3'b111)
			return id_pkg::SEL_LOGIC;
		if (f3 == 3'b001 || f3 == 3'b101)
			return id_pkg::SEL_SHIFT;
		return id_pkg::SEL_ARITH;
	endfunction

	// expected decode result straight from the rv32i encoding rules
	function automatic expect_t predict_stage(input logic [31:0] inst, input logic [31:0] pc);
		expect_t e;
		logic [2:0] f3;
		logic [6:0] f7;
		logic [4:0] rs1;
		logic [4:0] rs2;
		logic [4:0] rd;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] imm_i;
		logic [31:0] imm_b;
		logic [31:0] imm_u;
		logic [31:0] imm_j;
		logic shift;
		e = '0;
		f3 = inst[14:12];
		f7 = inst[31:25];
		rs1 = inst[19:15];
		rs2 = inst[24:20];
		rd = inst[11:7];
		a = forward_value(rs1);
		b = forward_value(rs2);
		imm_i = {{20{inst[31]}}, inst[31:20]};
		imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
		imm_u = {inst[31:12], 12'b0};
		imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
		shift = (f3 == 3'b001 || f3 == 3'b101);
		case (inst[6:0])
			id_pkg::OPC_OP:
				if (f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'b000 || f3 == 3'b101))) begin
					e.op = arith_op(f3, f7[5]);
					e.sel = sel_for_f3(f3);
					e.use1 = 1'b1;
					e.use2 = 1'b1;
					e.r1 = a;
					e.r2 = b;
					e.wreg = 1'b1;
					e.wd = rd;
				end
			id_pkg::OPC_OP_IMM:
				if (!shift || f7 == 7'h00 || (f3 == 3'b101 && f7 == 7'h20)) begin
					e.op = arith_op(f3, shift && f7[5]);
					e.sel = sel_for_f3(f3);
					e.use1 = 1'b1;
					e.r1 = a;
					e.r2 = shift ? {27'd0, inst[24:20]} : imm_i;
					e.wreg = 1'b1;
					e.wd = rd;
				end
			id_pkg::OPC_BRANCH:
				if (f3 != 3'b010 && f3 != 3'b011) begin
					e.sel = id_pkg::SEL_JUMP_BRANCH;
					e.use1 = 1'b1;
					e.use2 = 1'b1;
					e.r1 = a;
					e.r2 = b;
					case (f3)
						3'b000:  e.op = id_pkg::ALU_BEQ;
						3'b001:  e.op = id_pkg::ALU_BNE;
						3'b100:  e.op = id_pkg::ALU_BLT;
						3'b101:  e.op = id_pkg::ALU_BGE;
						3'b110:  e.op = id_pkg::ALU_BLTU;
						default: e.op = id_pkg::ALU_BGEU;
					endcase
					case (f3)
						3'b000:  e.flag = (a == b);
						3'b001:  e.flag = (a != b);
						3'b100:  e.flag = $signed(a) < $signed(b);
						3'b101:  e.flag = $signed(a) >= $signed(b);
						3'b110:  e.flag = a < b;
						default: e.flag = a >= b;
					endcase
					e.tgt = e.flag ? pc + imm_b : 32'd0;
				end
			id_pkg::OPC_LOAD:
				if (f3 != 3'b011 && f3 < 3'b110) begin
					case (f3)
						3'b000:  e.op = id_pkg::ALU_LB;
						3'b001:  e.op = id_pkg::ALU_LH;
						3'b010:  e.op = id_pkg::ALU_LW;
						3'b100:  e.op = id_pkg::ALU_LBU;
						default: e.op = id_pkg::ALU_LHU;
					endcase
					e.sel = id_pkg::SEL_LOAD_STORE;
					e.use1 = 1'b1;
					e.r1 = a;
					e.r2 = imm_i;
					e.wreg = 1'b1;
					e.wd = rd;
				end
			id_pkg::OPC_STORE:
				if (f3 < 3'b011) begin
					e.op = (f3 == 3'b000) ? id_pkg::ALU_SB :
						(f3 == 3'b001) ? id_pkg::ALU_SH : id_pkg::ALU_SW;
					e.sel = id_pkg::SEL_LOAD_STORE;
					e.use1 = 1'b1;
					e.use2 = 1'b1;
					e.r1 = a;
					e.r2 = b;
				end
			id_pkg::OPC_LUI: begin
				e.op = id_pkg::ALU_OR;
				e.sel = id_pkg::SEL_LOGIC;
				e.r2 = imm_u;
				e.wreg = 1'b1;
				e.wd = rd;
			end
			id_pkg::OPC_AUIPC: begin
				e.op = id_pkg::ALU_ADD;
				e.sel = id_pkg::SEL_ARITH;
				e.r1 = pc;
				e.r2 = imm_u;
				e.wreg = 1'b1;
				e.wd = rd;
			end
			id_pkg::OPC_JAL: begin
				e.op = id_pkg::ALU_JAL;
				e.sel = id_pkg::SEL_JUMP_BRANCH;
				e.wreg = 1'b1;
				e.wd = 5'(`ID_LINK_REG);
				e.flag = 1'b1;
				e.tgt = pc + imm_j;
				e.link = pc + 32'd4;
			end
			id_pkg::OPC_JALR:
				if (f3 == 3'b000) begin
					e.op = id_pkg::ALU_JALR;
					e.sel = id_pkg::SEL_JUMP_BRANCH;
					e.use1 = 1'b1;
					e.r1 = a;
					e.r2 = imm_i;
					e.wreg = 1'b1;
					e.wd = 5'(`ID_LINK_REG);
					e.flag = 1'b1;
					e.tgt = (a + imm_i) & ~32'd1;
					e.link = pc + 32'd4;
				end
			default: ;
		endcase
		e.load = e.wreg && e.sel == id_pkg::SEL_LOAD_STORE;
		e.stall = ex_load && ex_wd != 5'd0 &&
			((e.use1 && rs1 == ex_wd) || (e.use2 && rs2 == ex_wd));
		return e;
	endfunction

	task automatic check_issue(input id_pkg::aluop_e exp_op, input id_pkg::alusel_e exp_sel,
			input logic [4:0] exp_wd, input logic exp_wreg, input logic chk_wd,
			input logic chk_data, input logic [31:0] exp_r1, input logic [31:0] exp_r2,
			input logic [31:0] exp_inst);
		if (aluop_o != exp_op || alusel_o != exp_sel || wreg_o != exp_wreg)
			report_mismatch($sformatf("issue op %s/%s wreg %0b, got %s/%s wreg %0b",
				exp_op.name(), exp_sel.name(), exp_wreg,
				aluop_o.name(), alusel_o.name(), wreg_o));
		if (chk_wd && wd_o != exp_wd)
			report_mismatch($sformatf("wd expected %0d got %0d", exp_wd, wd_o));
		if (chk_data && (reg1_o != exp_r1 || reg2_o != exp_r2 || inst_o != exp_inst))
			report_mismatch($sformatf("operands expected %h %h got %h %h (inst %h)",
				exp_r1, exp_r2, reg1_o, reg2_o, inst_o));
	endtask

	task automatic check_branch(input logic exp_flag, input logic [31:0] exp_tgt,
			input logic [31:0] exp_link);
		if (branch_flag_o != exp_flag || branch_target_o != exp_tgt || link_addr_o != exp_link)
			report_mismatch($sformatf("branch expected %0b %h %h got %0b %h %h", exp_flag,
				exp_tgt, exp_link, branch_flag_o, branch_target_o, link_addr_o));
	endtask

	task automatic check_stall(input logic exp);
		if (stall_o != exp)
			report_mismatch($sformatf("stall expected %0b got %0b", exp, stall_o));
	endtask

	task automatic verify_read_ports(input logic exp_rd1, input logic exp_rd2,
			input logic [4:0] exp_a1, input logic [4:0] exp_a2);
		if (reg1_read_o != exp_rd1 || reg2_read_o != exp_rd2)
			report_mismatch($sformatf("read enables expected %0b %0b got %0b %0b",
				exp_rd1, exp_rd2, reg1_read_o, reg2_read_o));
		if ((exp_rd1 && reg1_addr_o != exp_a1) || (exp_rd2 && reg2_addr_o != exp_a2))
			report_mismatch($sformatf("read addresses expected %0d %0d got %0d %0d",
				exp_a1, exp_a2, reg1_addr_o, reg2_addr_o));
	endtask

	// outputs sampled mid-cycle on the falling edge
	always @(negedge clk) begin
		if (checking) begin
			check_issue(pend.op, pend.sel, pend.wd, pend.wreg,
				pend.wreg || pend.op == id_pkg::ALU_NOP, !pend_bubble,
				pend.r1, pend.r2, pend_inst);
			now_exp = predict_stage(inst_i, pc_i);
			verify_read_ports(now_exp.use1, now_exp.use2, inst_i[19:15], inst_i[24:20]);
			check_stall(now_exp.stall);
			check_branch(now_exp.flag, now_exp.tgt, now_exp.link);
			if (now_exp.stall)
				n_stall++;
			if (now_exp.flag)
				n_taken++;
			pend = now_exp;
			pend_bubble = now_exp.stall;
			pend_inst = inst_i;
			if (now_exp.stall) begin // bubble enters ID/EX
				pend.op = id_pkg::ALU_NOP;
				pend.sel = id_pkg::SEL_NOP;
				pend.wd = '0;
				pend.wreg = 1'b0;
				pend.load = 1'b0;
			end
			ex_wd = pend.wd;
			ex_wreg = pend.wreg;
			ex_load = pend.load;
			exp_stall = now_exp.stall;
		end
	end

	function automatic logic [31:0] make_inst();
		logic [4:0] rd;
		logic [4:0] rs1;
		logic [4:0] rs2;
		logic [2:0] f3;
		logic [6:0] f7;
		logic [11:0] hi;
		rd = 5'(rand_bits(2)); // x0..x3 keeps dependencies frequent
		rs1 = 5'(rand_bits(2));
		rs2 = 5'(rand_bits(2));
		f3 = 3'(rand_bits(3));
		hi = 12'(rand_bits(12));
		f7 = rand_bits(1) != 0 ? 7'h20 : 7'h00;
		case (4'(rand_bits(4)))
			4'd0, 4'd1, 4'd14: begin
				if (3'(rand_bits(3)) == 3'd0)
					f7 = 7'(rand_bits(7));
				return {f7, rs2, rs1, f3, rd, id_pkg::OPC_OP};
			end
			4'd2, 4'd3, 4'd15: begin
				if (f3[1:0] == 2'b01)
					hi[11:5] = f7;
				return {hi, rs1, f3, rd, id_pkg::OPC_OP_IMM};
			end
			4'd4, 4'd5: return {hi[11:5], rs2, rs1, f3, hi[4:0], id_pkg::OPC_BRANCH};
			4'd6, 4'd7: return {hi, rs1, f3, rd, id_pkg::OPC_LOAD};
			4'd8:  return {hi[11:5], rs2, rs1, f3, hi[4:0], id_pkg::OPC_STORE};
			4'd9:  return {20'(rand_bits(20)), rd, id_pkg::OPC_LUI};
			4'd10: return {20'(rand_bits(20)), rd, id_pkg::OPC_AUIPC};
			4'd11: return {20'(rand_bits(20)), rd, id_pkg::OPC_JAL};
			4'd12: return {hi, rs1, (f3[1:0] == 2'b00) ? f3 : 3'b000, rd, id_pkg::OPC_JALR};
			default: return rand_bits(32);
		endcase
	endfunction

	task automatic drive_side_inputs();
		ex_wdata_i = rand_bits(32);
		mem_wreg_i = rand_bits(1) != 0;
		mem_wd_i = 5'(rand_bits(2));
		mem_wdata_i = rand_bits(32);
	endtask

	// watchdog over the whole run
	initial begin
		#((NUM_INST + 20) * 2 * CLK_HALF);
		abort_run("run did not finish in time");
	end

	initial begin
		int i;
		lfsr = 32'h7dcd_4ee9;
		for (i = 0; i < 32; i++)
			rf[i] = (32'h9e37_79b9 * (i + 1)) ^ {i[4:0], 27'h5a5_a5a5};
		checking = 1'b0;
		exp_stall = 1'b0;
		pend_bubble = 1'b1;
		ex_wreg = 1'b0;
		ex_load = 1'b0;
		ex_wd = '0;
		n_stall = 0;
		n_taken = 0;
		pend = '0;
		pend_inst = '0;
		reset_i = 1'b1;
		inst_i = 32'h0000_0013;
		pc_i = '0;
		ex_wdata_i = '0;
		mem_wreg_i = 1'b0;
		mem_wd_i = '0;
		mem_wdata_i = '0;
		repeat (2) @(posedge clk);
		#5 reset_i = 1'b0;
		checking = 1'b1;
		for (i = 0; i < NUM_INST; i++) begin
			@(posedge clk);
			#5;
			if (!exp_stall) begin // fetch holds inst and pc on a stall
				inst_i = make_inst();
				pc_i = 32'(rand_bits(30)) << 2;
			end
			drive_side_inputs();
		end
		repeat (2) @(posedge clk);
		checking = 1'b0;
		if (n_stall > 0 && n_taken > 0) begin
			$display("SIMULATION PASSED");
			$finish;
		end else begin
			$display("Error: stall or taken branch never exercised");
			$display("SIMULATION FAILED");
			$fatal(1, "incomplete run");
		end
	end

endmodule

//--- filelist.f
+incdir+common
common/id_pkg.sv
decode/id_decoder.sv
decode/imm_gen.sv
design/operand_mux.sv
design/hazard_unit.sv
design/branch_unit.sv
design/id_ex_reg.sv
design/id_stage.sv
verification/id_stage_assert.sv
verification/tb_id_stage.sv

//--- run_sim.sh
#!/bin/sh
# build and run the decode stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f filelist.f --top-module tb_id_stage -o tb_id_stage
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit $status
fi

./obj_dir/tb_id_stage
status=$?
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit $status
fi

exit 0
